/* ex_pkg.sv */
// Execute stage shared definitions
// Data widths, operator encodings, multiplier states and the
// request and write bundles passed between the execute blocks

package ex_pkg;

  ////////////////////
  // Widths
  ////////////////////

  // Data path width of the integer core
  localparam int WORD_W     = 32;
  // Register file write address, 64 entries
  localparam int REG_ADDR_W = 6;

  typedef logic [WORD_W-1:0]     word_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  ////////////////////
  // Encodings
  ////////////////////

  // ALU operator, arithmetic and logic first, then compares
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_SLT, ALU_SLTU, ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
  } alu_op_e;

  // Multiplier operator, low word or signed/unsigned high word
  typedef enum logic [1:0] {
    MUL_L  = 2'd0,
    MUL_H  = 2'd1,
    MUL_HU = 2'd2
  } mul_op_e;

  // High product sequencer
  typedef enum logic [1:0] {
    MULT_IDLE = 2'd0,
    MULT_STEP = 2'd1,
    MULT_DONE = 2'd2
  } mult_state_e;

  ////////////////////
  // Bundles
  ////////////////////

  typedef struct packed {
    alu_op_e operator;
    word_t   operand_a;
    word_t   operand_b;
    // Jump target, passed through for the fetch stage
    word_t   operand_c;
  } alu_req_t;

  typedef struct packed {
    mul_op_e operator;
    word_t   op_a;
    word_t   op_b;
  } mult_req_t;

  // One register file write port
  typedef struct packed {
    logic      we;
    reg_addr_t waddr;
    word_t     wdata;
  } rf_wr_t;

endpackage

/* alu_unit.sv */
// Integer ALU of the execute stage
// Single cycle add, subtract, logic, shifts and compares
// Compare operators also drive the branch decision flag

`timescale 1ns/100ps

module alu_unit (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             enable_i,
  input  ex_pkg::alu_req_t req_i,
  output ex_pkg::word_t    result_o,
  output logic             cmp_result_o
);

  import ex_pkg::*;

  word_t      op_a;
  word_t      op_b;
  logic [4:0] shamt;
  logic       is_eq;
  logic       is_lt;
  logic       is_ltu;
  logic       is_cmp_op;

  assign op_a  = req_i.operand_a;
  assign op_b  = req_i.operand_b;
  // Only the low five bits count for a 32-bit shift
  assign shamt = op_b[4:0];

  ////////////////////
  // Comparator
  ////////////////////

  assign is_eq  = (op_a == op_b);
  assign is_lt  = ($signed(op_a) < $signed(op_b));
  assign is_ltu = (op_a < op_b);

  // Set-less-than and branch compares return a flag
  assign is_cmp_op = req_i.operator inside {ALU_SLT, ALU_SLTU, ALU_EQ, ALU_NE,
                                             ALU_LT, ALU_GE, ALU_LTU, ALU_GEU};

  ////////////////////
  // Result select
  ////////////////////

  always_comb begin
    result_o     = '0;
    cmp_result_o = 1'b0;
    unique case (req_i.operator)
      ALU_ADD:  result_o = op_a + op_b;
      ALU_SUB:  result_o = op_a - op_b;
      ALU_AND:  result_o = op_a & op_b;
      ALU_OR:   result_o = op_a | op_b;
      ALU_XOR:  result_o = op_a ^ op_b;
      ALU_SLL:  result_o = op_a << shamt;
      ALU_SRL:  result_o = op_a >> shamt;
      // Arithmetic shift keeps the sign bit
      ALU_SRA:  result_o = $signed(op_a) >>> shamt;
      ALU_SLT:  cmp_result_o = is_lt;
      ALU_SLTU: cmp_result_o = is_ltu;
      ALU_EQ:   cmp_result_o = is_eq;
      ALU_NE:   cmp_result_o = !is_eq;
      ALU_LT:   cmp_result_o = is_lt;
      ALU_GE:   cmp_result_o = !is_lt;
      ALU_LTU:  cmp_result_o = is_ltu;
      ALU_GEU:  cmp_result_o = !is_ltu;
    endcase

    // Flag as a zero extended word
    if (is_cmp_op) begin
      result_o = {{(WORD_W-1){1'b0}}, cmp_result_o};
    end
  end

  ////////////////////
  // Checks
  ////////////////////

  // Decode must hand over a known operator whenever the ALU is used
  a_op_known : assert property (
    @(posedge clk) disable iff (!rst_n)
    enable_i |-> !$isunknown(req_i.operator)
  );

endmodule

/* mult_unit.sv */
// Integer multiplier of the execute stage
// MUL returns the low product in the same cycle
// MULH and MULHU run a short sequence over 16-bit partial products
// and return the high word two edges after the request

`timescale 1ns/100ps

module mult_unit (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              enable_i,
  input  logic              ex_ready_i,
  input  ex_pkg::mult_req_t req_i,
  output ex_pkg::word_t     result_o,
  output logic              multicycle_o,
  output logic              ready_o
);

  import ex_pkg::*;

  mult_state_e        state_q;
  mult_state_e        state_d;
  logic               hi_op;
  logic               hi_signed;
  word_t              low_prod;
  logic signed [16:0] a_lo;
  logic signed [16:0] a_hi;
  logic signed [16:0] b_lo;
  logic signed [16:0] b_hi;
  logic signed [33:0] pp_ll_q;
  logic signed [33:0] pp_lh_q;
  logic signed [33:0] pp_hl_q;
  logic signed [33:0] pp_hh_q;
  logic signed [63:0] pp_ll_x;
  logic signed [63:0] pp_lh_x;
  logic signed [63:0] pp_hl_x;
  logic signed [63:0] pp_hh_x;
  logic signed [63:0] hi_sum;

  assign hi_op     = (req_i.operator == MUL_H) || (req_i.operator == MUL_HU);
  assign hi_signed = (req_i.operator == MUL_H);

  // Truncated product is the same for signed and unsigned
  assign low_prod = req_i.op_a * req_i.op_b;

  ////////////////////
  // Operand halves
  ////////////////////

  // Low halves are always positive, high halves carry the sign for MULH
  assign a_lo = {1'b0, req_i.op_a[15:0]};
  assign b_lo = {1'b0, req_i.op_b[15:0]};
  assign a_hi = {hi_signed & req_i.op_a[31], req_i.op_a[31:16]};
  assign b_hi = {hi_signed & req_i.op_b[31], req_i.op_b[31:16]};

  // Partial products captured at the end of STEP
  always_ff @(posedge clk) begin
    if (state_q == MULT_STEP) begin
      pp_ll_q <= a_lo * b_lo;
      pp_lh_q <= a_lo * b_hi;
      pp_hl_q <= a_hi * b_lo;
      pp_hh_q <= a_hi * b_hi;
    end
  end

  // Recombine in DONE with sign extended partials
  always_comb begin
    pp_ll_x = pp_ll_q;
    pp_lh_x = pp_lh_q;
    pp_hl_x = pp_hl_q;
    pp_hh_x = pp_hh_q;
    hi_sum  = pp_ll_x + (pp_lh_x <<< 16) + (pp_hl_x <<< 16) + (pp_hh_x <<< 32);
  end

  ////////////////////
  // Sequencer
  ////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      MULT_IDLE: if (enable_i && hi_op) state_d = MULT_STEP;
      MULT_STEP: state_d = MULT_DONE;
      // Hold the high word until the stage moves on
      MULT_DONE: if (ex_ready_i) state_d = MULT_IDLE;
      default:   state_d = MULT_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= MULT_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign multicycle_o = (state_q != MULT_IDLE);
  // Busy while a high word request is starting or in STEP
  assign ready_o      = (state_q == MULT_DONE) ||
                        ((state_q == MULT_IDLE) && !(enable_i && hi_op));
  assign result_o     = (state_q == MULT_DONE) ? hi_sum[63:32] : low_prod;

  // Decode holds the request for the whole high word sequence
  a_req_stable : assert property (
    @(posedge clk) disable iff (!rst_n)
    (state_q != MULT_IDLE) |-> $stable(req_i)
  );

endmodule

/* ex_writeback.sv */
// Execute stage result combiner
// Selects CSR, multiplier or ALU data for the forwarding write,
// holds the EX/WB register of the load write port and
// forms the ready and valid levels of the stage

`timescale 1ns/100ps

module ex_writeback (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              alu_en_i,
  input  logic              mult_en_i,
  input  logic              csr_access_i,
  input  logic              lsu_en_i,
  input  logic              branch_in_ex_i,
  input  logic              lsu_ready_ex_i,
  input  logic              lsu_err_i,
  input  logic              wb_ready_i,
  input  logic              mult_ready_i,
  input  logic              regfile_alu_we_i,
  input  logic              regfile_we_i,
  input  ex_pkg::word_t     alu_result_i,
  input  ex_pkg::word_t     mult_result_i,
  input  ex_pkg::word_t     csr_rdata_i,
  input  ex_pkg::word_t     lsu_rdata_i,
  input  ex_pkg::reg_addr_t regfile_alu_waddr_i,
  input  ex_pkg::reg_addr_t regfile_waddr_i,
  output ex_pkg::rf_wr_t    regfile_alu_fw_o,
  output ex_pkg::rf_wr_t    regfile_wb_o,
  output logic              ex_ready_o,
  output logic              ex_valid_o
);

  import ex_pkg::*;

  word_t     fw_wdata;
  logic      units_ready;
  logic      lsu_we_next;
  logic      lsu_we_q;
  reg_addr_t lsu_waddr_q;

  ////////////////////
  // Forwarding port
  ////////////////////

  // CSR read wins, then multiplier, then ALU
  always_comb begin
    if (csr_access_i) begin
      fw_wdata = csr_rdata_i;
    end else if (mult_en_i) begin
      fw_wdata = mult_result_i;
    end else if (alu_en_i) begin
      fw_wdata = alu_result_i;
    end else begin
      fw_wdata = '0;
    end
  end

  assign regfile_alu_fw_o = '{we: regfile_alu_we_i, waddr: regfile_alu_waddr_i, wdata: fw_wdata};

  ////////////////////
  // Stall logic
  ////////////////////

  assign units_ready = mult_ready_i & lsu_ready_ex_i & wb_ready_i;
  // Branches resolve here and never wait for writeback
  assign ex_ready_o  = units_ready | branch_in_ex_i;
  assign ex_valid_o  = (alu_en_i | mult_en_i | csr_access_i | lsu_en_i) & units_ready;

  ////////////////////
  // EX/WB register
  ////////////////////

  // A faulting load must not write the register file
  assign lsu_we_next = regfile_we_i & ~lsu_err_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lsu_we_q <= 1'b0;
    end else if (ex_valid_o) begin
      lsu_we_q <= lsu_we_next;
    end else if (wb_ready_i) begin
      // Writeback took the old entry and nothing new arrived
      lsu_we_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (ex_valid_o && lsu_we_next) begin
      lsu_waddr_q <= regfile_waddr_i;
    end
  end

  // Load data arrives from the LSU in the writeback cycle
  assign regfile_wb_o = '{we: lsu_we_q, waddr: lsu_waddr_q, wdata: lsu_rdata_i};

  // Decode issues to one result source at a time
  a_one_source : assert property (
    @(posedge clk) disable iff (!rst_n)
    $onehot0({alu_en_i, mult_en_i, csr_access_i})
  );

endmodule

/* ex_stage.sv */
// Integer execute stage, top level
// ALU and multiplier work side by side, the writeback combiner
// merges their results and forms the stage handshake levels
// Branch decision and jump target go straight back to fetch

`timescale 1ns/100ps

module ex_stage (
  input  logic              clk,
  input  logic              rst_n,
  // From decode
  input  logic              alu_en_i,
  input  ex_pkg::alu_req_t  alu_req_i,
  input  logic              mult_en_i,
  input  ex_pkg::mult_req_t mult_req_i,
  input  logic              csr_access_i,
  input  ex_pkg::word_t     csr_rdata_i,
  // Destinations
  input  logic              regfile_alu_we_i,
  input  ex_pkg::reg_addr_t regfile_alu_waddr_i,
  input  logic              regfile_we_i,
  input  ex_pkg::reg_addr_t regfile_waddr_i,
  // Control
  input  logic              branch_in_ex_i,
  input  logic              lsu_en_i,
  input  logic              lsu_ready_ex_i,
  input  logic              lsu_err_i,
  input  ex_pkg::word_t     lsu_rdata_i,
  input  logic              wb_ready_i,
  // Results
  output ex_pkg::rf_wr_t    regfile_alu_fw_o,
  output ex_pkg::rf_wr_t    regfile_wb_o,
  output ex_pkg::word_t     jump_target_o,
  output logic              branch_decision_o,
  output logic              mult_multicycle_o,
  output logic              ex_ready_o,
  output logic              ex_valid_o
);

  import ex_pkg::*;

  word_t alu_result;
  logic  alu_cmp;
  word_t mult_result;
  logic  mult_ready;

  ////////////////////
  // Branch outputs
  ////////////////////

  assign branch_decision_o = alu_cmp;
  assign jump_target_o     = alu_req_i.operand_c;

  alu_unit u_alu (
    .clk          (clk),
    .rst_n        (rst_n),
    .enable_i     (alu_en_i),
    .req_i        (alu_req_i),
    .result_o     (alu_result),
    .cmp_result_o (alu_cmp)
  );

  // Stage ready releases the held high word
  mult_unit u_mult (
    .clk          (clk),
    .rst_n        (rst_n),
    .enable_i     (mult_en_i),
    .ex_ready_i   (ex_ready_o),
    .req_i        (mult_req_i),
    .result_o     (mult_result),
    .multicycle_o (mult_multicycle_o),
    .ready_o      (mult_ready)
  );

  ex_writeback u_wb (
    .clk                 (clk),
    .rst_n               (rst_n),
    .alu_en_i            (alu_en_i),
    .mult_en_i           (mult_en_i),
    .csr_access_i        (csr_access_i),
    .lsu_en_i            (lsu_en_i),
    .branch_in_ex_i      (branch_in_ex_i),
    .lsu_ready_ex_i      (lsu_ready_ex_i),
    .lsu_err_i           (lsu_err_i),
    .wb_ready_i          (wb_ready_i),
    .mult_ready_i        (mult_ready),
    .regfile_alu_we_i    (regfile_alu_we_i),
    .regfile_we_i        (regfile_we_i),
    .alu_result_i        (alu_result),
    .mult_result_i       (mult_result),
    .csr_rdata_i         (csr_rdata_i),
    .lsu_rdata_i         (lsu_rdata_i),
    .regfile_alu_waddr_i (regfile_alu_waddr_i),
    .regfile_waddr_i     (regfile_waddr_i),
    .regfile_alu_fw_o    (regfile_alu_fw_o),
    .regfile_wb_o        (regfile_wb_o),
    .ex_ready_o          (ex_ready_o),
    .ex_valid_o          (ex_valid_o)
  );

endmodule

/* tb_ex_model.svh */
// Reference model for the execute stage testbench
// Galois LFSR, ALU and compare rules, multiplier products
// and the next value of the load port write enable

`ifndef TB_EX_MODEL_SVH
`define TB_EX_MODEL_SVH

////////////////////
// Random source
////////////////////

// 16-bit Galois LFSR, taps x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsr_step(input logic [15:0] state);
  logic [15:0] next;
  next = state >> 1;
  if (state[0]) begin
    next = next ^ 16'hB400;
  end
  return next;
endfunction

////////////////////
// ALU rules
////////////////////

// Flag of the compare and set-less-than operators, 0 for the rest
function automatic logic model_cmp(input alu_op_e op, input word_t a, input word_t b);
  logic lt_s;
  logic lt_u;
  logic eq;
  eq   = (a == b);
  lt_u = (a < b);
  // Different signs decide by the sign of a alone
  lt_s = (a[31] != b[31]) ? a[31] : lt_u;
  case (op)
    ALU_SLT:  return lt_s;
    ALU_SLTU: return lt_u;
    ALU_EQ:   return eq;
    ALU_NE:   return !eq;
    ALU_LT:   return lt_s;
    ALU_GE:   return !lt_s;
    ALU_LTU:  return lt_u;
    ALU_GEU:  return !lt_u;
    default:  return 1'b0;
  endcase
endfunction

function automatic word_t model_alu(input alu_op_e op, input word_t a, input word_t b);
  logic [63:0] wide;
  logic [4:0]  sh;
  sh   = b[4:0];
  // Sign extended copy for the arithmetic right shift
  wide = {{32{a[31]}}, a} >> sh;
  case (op)
    ALU_ADD: return a + b;
    ALU_SUB: return a - b;
    ALU_AND: return a & b;
    ALU_OR:  return a | b;
    ALU_XOR: return a ^ b;
    ALU_SLL: return a << sh;
    ALU_SRL: return a >> sh;
    ALU_SRA: return wide[31:0];
    default: return {31'b0, model_cmp(op, a, b)};
  endcase
endfunction

////////////////////
// Multiplier rules
////////////////////

function automatic word_t model_mul_lo(input word_t a, input word_t b);
  logic [63:0] prod;
  prod = {32'b0, a} * {32'b0, b};
  return prod[31:0];
endfunction

// High word of the full 64-bit product
function automatic word_t model_mul_hi(input logic is_signed, input word_t a, input word_t b);
  logic [63:0] ea;
  logic [63:0] eb;
  logic [63:0] prod;
  ea   = is_signed ? {{32{a[31]}}, a} : {32'b0, a};
  eb   = is_signed ? {{32{b[31]}}, b} : {32'b0, b};
  prod = ea * eb;
  return prod[63:32];
endfunction

////////////////////
// Load port
////////////////////

function automatic logic load_we_next(input logic valid, input logic we_in, input logic err,
                                      input logic wb_ready, input logic we_q);
  if (valid) begin
    return we_in & !err;
  end
  // Writeback drains the entry when nothing new comes in
  if (wb_ready) begin
    return 1'b0;
  end
  return we_q;
endfunction

`endif

/* tb_ex_stage.sv */
// Testbench of the integer execute stage
// Random ALU, branch, multiplier, load port and CSR traffic
// checked against the reference model functions

`timescale 1ns/100ps

module tb_ex_stage;

  import ex_pkg::*;

  localparam logic [15:0] SEED = 16'd43321;
  localparam int CLK_PERIOD = 4;
  localparam int N_ALU      = 200;
  localparam int N_BRANCH   = 100;
  localparam int N_MUL_LO   = 100;
  localparam int N_MUL_HI   = 40;
  localparam int MAX_STALL  = 6;
  localparam int N_LOAD     = 200;
  localparam int N_CSR      = 150;
  // Every high word operation takes at most MAX_STALL + 4 cycles
  localparam int TOTAL_CYCLES = 8 + N_ALU + N_BRANCH + N_MUL_LO +
                                N_MUL_HI * (MAX_STALL + 4) + N_LOAD + N_CSR;
  localparam int TIMEOUT_NS = TOTAL_CYCLES * CLK_PERIOD * 4;

  logic        clk;
  logic        rst_n;
  logic        alu_en_i;
  alu_req_t    alu_req_i;
  logic        mult_en_i;
  mult_req_t   mult_req_i;
  logic        csr_access_i;
  word_t       csr_rdata_i;
  logic        regfile_alu_we_i;
  reg_addr_t   regfile_alu_waddr_i;
  logic        regfile_we_i;
  reg_addr_t   regfile_waddr_i;
  logic        branch_in_ex_i;
  logic        lsu_en_i;
  logic        lsu_ready_ex_i;
  logic        lsu_err_i;
  word_t       lsu_rdata_i;
  logic        wb_ready_i;
  rf_wr_t      regfile_alu_fw_o;
  rf_wr_t      regfile_wb_o;
  word_t       jump_target_o;
  logic        branch_decision_o;
  logic        mult_multicycle_o;
  logic        ex_ready_o;
  logic        ex_valid_o;
  logic [15:0] lfsr_state;

  `include "tb_ex_model.svh"

  ex_stage uut (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  // One output bit per LFSR step
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v          = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
    return v;
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      $display("error: %s expected %0h actual %0h", name, expected, actual);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  // Quiet stage, nothing issued and writeback ready
  task automatic idle_inputs();
    alu_en_i            = 1'b0;
    alu_req_i           = '0;
    mult_en_i           = 1'b0;
    mult_req_i          = '0;
    csr_access_i        = 1'b0;
    csr_rdata_i         = '0;
    regfile_alu_we_i    = 1'b0;
    regfile_alu_waddr_i = '0;
    regfile_we_i        = 1'b0;
    regfile_waddr_i     = '0;
    branch_in_ex_i      = 1'b0;
    lsu_en_i            = 1'b0;
    lsu_ready_ex_i      = 1'b1;
    lsu_err_i           = 1'b0;
    lsu_rdata_i         = '0;
    wb_ready_i          = 1'b1;
  endtask

  task automatic random_alu_req();
    alu_req_i.operator  = alu_op_e'(rand_bits(4));
    alu_req_i.operand_a = rand_bits(32);
    alu_req_i.operand_b = rand_bits(32);
    alu_req_i.operand_c = rand_bits(32);
  endtask

  ////////////////////
  // Watchdog
  ////////////////////

  initial begin
    #(TIMEOUT_NS);
    $display("timeout: the tests did not finish in %0d ns", TIMEOUT_NS);
    $display("TEST FAILED");
    $fatal(1);
  end

  ////////////////////
  // Tests
  ////////////////////

  initial begin
    logic  exp_we;
    logic  exp_valid;
    reg_addr_t exp_waddr;
    word_t exp_hi;
    logic  is_signed;
    logic  done;
    int    stalls;
    logic [1:0] src;
    word_t exp_fw;

    clk        = 1'b0;
    rst_n      = 1'b0;
    lfsr_state = SEED;
    idle_inputs();
    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    #1;
    check_value("reset: wb we", 0, regfile_wb_o.we);
    check_value("reset: multicycle", 0, mult_multicycle_o);

    // ALU results on the forwarding port
    repeat (N_ALU) begin
      @(negedge clk);
      random_alu_req();
      alu_en_i            = 1'b1;
      regfile_alu_we_i    = rand_bits(1);
      regfile_alu_waddr_i = rand_bits(REG_ADDR_W);
      #1;
      check_value("alu: wdata",
                  model_alu(alu_req_i.operator, alu_req_i.operand_a, alu_req_i.operand_b),
                  regfile_alu_fw_o.wdata);
      check_value("alu: we", regfile_alu_we_i, regfile_alu_fw_o.we);
      check_value("alu: waddr", regfile_alu_waddr_i, regfile_alu_fw_o.waddr);
    end

    // Branch compares, equal operands one time in two
    repeat (N_BRANCH) begin
      @(negedge clk);
      random_alu_req();
      alu_req_i.operator = alu_op_e'(ALU_EQ + (rand_bits(3) % 6));
      if (rand_bits(1)) begin
        alu_req_i.operand_b = alu_req_i.operand_a;
      end
      branch_in_ex_i = rand_bits(1);
      wb_ready_i     = rand_bits(1);
      #1;
      check_value("branch: decision",
                  model_cmp(alu_req_i.operator, alu_req_i.operand_a, alu_req_i.operand_b),
                  branch_decision_o);
      check_value("branch: target", alu_req_i.operand_c, jump_target_o);
      check_value("branch: ex_ready", wb_ready_i | branch_in_ex_i, ex_ready_o);
    end

    // Low product in the same cycle
    idle_inputs();
    repeat (N_MUL_LO) begin
      @(negedge clk);
      mult_en_i           = 1'b1;
      mult_req_i.operator = MUL_L;
      mult_req_i.op_a     = rand_bits(32);
      mult_req_i.op_b     = rand_bits(32);
      #1;
      check_value("mul_lo: wdata", model_mul_lo(mult_req_i.op_a, mult_req_i.op_b),
                  regfile_alu_fw_o.wdata);
      check_value("mul_lo: ex_ready", 1, ex_ready_o);
      check_value("mul_lo: multicycle", 0, mult_multicycle_o);
    end

    // High product after two edges, held through writeback stalls
    repeat (N_MUL_HI) begin
      @(negedge clk);
      is_signed           = rand_bits(1);
      mult_en_i           = 1'b1;
      mult_req_i.operator = is_signed ? MUL_H : MUL_HU;
      mult_req_i.op_a     = rand_bits(32);
      mult_req_i.op_b     = rand_bits(32);
      wb_ready_i          = 1'b1;
      exp_hi              = model_mul_hi(is_signed, mult_req_i.op_a, mult_req_i.op_b);
      #1;
      check_value("mul_hi: ex_ready at issue", 0, ex_ready_o);
      @(negedge clk);
      wb_ready_i = rand_bits(1);
      #1;
      check_value("mul_hi: ex_ready in step", 0, ex_ready_o);
      check_value("mul_hi: multicycle in step", 1, mult_multicycle_o);
      done   = 1'b0;
      stalls = 0;
      while (!done) begin
        @(negedge clk);
        wb_ready_i = (stalls >= MAX_STALL) ? 1'b1 : rand_bits(1);
        #1;
        check_value("mul_hi: wdata", exp_hi, regfile_alu_fw_o.wdata);
        check_value("mul_hi: multicycle in done", 1, mult_multicycle_o);
        check_value("mul_hi: ex_ready in done", wb_ready_i, ex_ready_o);
        if (wb_ready_i) begin
          done = 1'b1;
        end else begin
          stalls++;
        end
      end
      @(negedge clk);
      idle_inputs();
      #1;
      check_value("mul_hi: back to idle", 0, mult_multicycle_o);
    end

    // Load port register, no write was issued before this point
    exp_we    = 1'b0;
    exp_waddr = '0;
    repeat (N_LOAD) begin
      @(negedge clk);
      lsu_en_i        = rand_bits(1);
      lsu_ready_ex_i  = rand_bits(1);
      lsu_err_i       = (rand_bits(2) == 0);
      regfile_we_i    = rand_bits(1);
      regfile_waddr_i = rand_bits(REG_ADDR_W);
      lsu_rdata_i     = rand_bits(32);
      wb_ready_i      = rand_bits(1);
      exp_valid       = lsu_en_i & lsu_ready_ex_i & wb_ready_i;
      #1;
      check_value("load: ex_valid", exp_valid, ex_valid_o);
      check_value("load: we", exp_we, regfile_wb_o.we);
      check_value("load: wdata", lsu_rdata_i, regfile_wb_o.wdata);
      if (exp_we) begin
        check_value("load: waddr", exp_waddr, regfile_wb_o.waddr);
      end
      // Address is taken on the same edge that sets we
      if (exp_valid && regfile_we_i && !lsu_err_i) begin
        exp_waddr = regfile_waddr_i;
      end
      exp_we = load_we_next(exp_valid, regfile_we_i, lsu_err_i, wb_ready_i, exp_we);
    end

    // CSR priority and the valid rule
    idle_inputs();
    repeat (N_CSR) begin
      @(negedge clk);
      random_alu_req();
      src                 = rand_bits(2);
      alu_en_i            = (src == 2'd1);
      mult_en_i           = (src == 2'd2);
      csr_access_i        = (src == 2'd3);
      mult_req_i.operator = MUL_L;
      mult_req_i.op_a     = rand_bits(32);
      mult_req_i.op_b     = rand_bits(32);
      csr_rdata_i         = rand_bits(32);
      lsu_en_i            = rand_bits(1);
      lsu_ready_ex_i      = rand_bits(1);
      wb_ready_i          = rand_bits(1);
      case (src)
        2'd1:    exp_fw = model_alu(alu_req_i.operator, alu_req_i.operand_a,
                                    alu_req_i.operand_b);
        2'd2:    exp_fw = model_mul_lo(mult_req_i.op_a, mult_req_i.op_b);
        2'd3:    exp_fw = csr_rdata_i;
        default: exp_fw = '0;
      endcase
      #1;
      check_value("csr: wdata", exp_fw, regfile_alu_fw_o.wdata);
      check_value("csr: ex_valid", ((src != 0) | lsu_en_i) & lsu_ready_ex_i & wb_ready_i,
                  ex_valid_o);
      check_value("csr: ex_ready", lsu_ready_ex_i & wb_ready_i, ex_ready_o);
    end

    @(negedge clk);
    idle_inputs();
    $display("TEST PASSED");
    $finish;
  end

endmodule

/* ex_stage.f */
+incdir+.
ex_pkg.sv
alu_unit.sv
mult_unit.sv
ex_writeback.sv
ex_stage.sv
tb_ex_stage.sv
